// ==== hdl/csr_counters.sv ====
`default_nettype none

module csr_counters (
	input wire logic                CLK,
	input wire logic                rst_n,
	input wire logic                instr_retire,
	input wire csr_pkg::csr_addr_t  csr_addr,
	input wire logic                csr_we,
	input wire csr_pkg::csr_word_t  csr_new,
	output csr_pkg::csr_word_t      mcycle,
	output csr_pkg::csr_word_t      minstret
);

	logic mcycle_wr;
	logic minstret_wr;

	// csr write to a counter
	assign mcycle_wr = csr_we && (csr_addr == csr_pkg::ADDR_MCYCLE);
	assign minstret_wr = csr_we && (csr_addr == csr_pkg::ADDR_MINSTRET);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mcycle <= '0;
			minstret <= '0;
		end else begin
			// written value wins over the increment
			if (mcycle_wr) begin
				mcycle <= csr_new;
			end else begin
				mcycle <= mcycle + 64'd1;
			end
			if (minstret_wr) begin
				minstret <= csr_new;
			end else if (instr_retire) begin
				minstret <= minstret + 64'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/csr_exec.sv ====
`default_nettype none

module csr_exec (
	input wire logic                csr_valid,
	input wire csr_pkg::csr_op_e    csr_op,
	input wire csr_pkg::csr_addr_t  csr_addr,
	input wire csr_pkg::csr_word_t  csr_wdata,
	input wire logic                csr_rs1_zero,
	input wire csr_pkg::csr_word_t  csr_old,
	input wire logic                trap_take,
	output logic                    csr_illegal,
	output logic                    csr_we,
	output csr_pkg::csr_word_t      csr_new
);

	logic addr_known;
	logic addr_read_only;
	logic wants_write;

	// implemented address map
	always_comb begin
		case (csr_addr)
			csr_pkg::ADDR_MVENDORID,
			csr_pkg::ADDR_MARCHID,
			csr_pkg::ADDR_MIMPID,
			csr_pkg::ADDR_MHARTID,
			csr_pkg::ADDR_MSTATUS,
			csr_pkg::ADDR_MISA,
			csr_pkg::ADDR_MIE,
			csr_pkg::ADDR_MTVEC,
			csr_pkg::ADDR_MSCRATCH,
			csr_pkg::ADDR_MEPC,
			csr_pkg::ADDR_MCAUSE,
			csr_pkg::ADDR_MTVAL,
			csr_pkg::ADDR_MIP,
			csr_pkg::ADDR_MCYCLE,
			csr_pkg::ADDR_MINSTRET: addr_known = 1'b1;
			default:                addr_known = 1'b0;
		endcase
	end

	// top two address bits set means read only
	assign addr_read_only = (csr_addr[11:10] == 2'b11);

	// csrrw always writes, set and clear only with a nonzero rs1
	assign wants_write = (csr_op == csr_pkg::CSR_RW) || !csr_rs1_zero;

	assign csr_illegal = csr_valid && (!addr_known || (addr_read_only && wants_write));

	// trap in this cycle kills the write
	assign csr_we = csr_valid && addr_known && !addr_read_only && wants_write && !trap_take;

	// new value from the old one
	always_comb begin
		case (csr_op)
			csr_pkg::CSR_RW: csr_new = csr_wdata;
			csr_pkg::CSR_RS: csr_new = csr_old | csr_wdata;
			csr_pkg::CSR_RC: csr_new = csr_old & ~csr_wdata;
			default:         csr_new = csr_wdata;
		endcase
	end

	// opcode must be driven whenever an access is presented
	always_comb begin
		if (csr_valid) begin
			a_op_known: assert final (!$isunknown(csr_op))
				else $error("csr_op unknown while csr_valid is high");
		end
	end

endmodule

`default_nettype wire

// ==== hdl/csr_file.sv ====
`default_nettype none

module csr_file (
	input wire logic                CLK,
	input wire logic                rst_n,
	input wire csr_pkg::csr_addr_t  csr_addr,
	input wire logic                csr_we,
	input wire csr_pkg::csr_word_t  csr_new,
	input wire logic                irq_soft,
	input wire logic                irq_timer,
	input wire logic                irq_ext,
	input wire logic                trap_take,
	input wire csr_pkg::csr_word_t  trap_mcause,
	input wire csr_pkg::csr_word_t  trap_mepc,
	input wire csr_pkg::csr_word_t  trap_mtval,
	input wire logic                mret_take,
	input wire csr_pkg::csr_word_t  mcycle,
	input wire csr_pkg::csr_word_t  minstret,
	output csr_pkg::csr_word_t      csr_rdata,
	output logic                    mstatus_mie,
	output csr_pkg::csr_word_t      mpending,
	output csr_pkg::csr_word_t      mtvec_base,
	output csr_pkg::csr_word_t      mepc
);

	// only mie and mpie are stored for mstatus
	logic mstatus_mie_q;
	logic mstatus_mpie_q;

	csr_pkg::csr_word_t mie_q;
	csr_pkg::csr_word_t mip_q;
	csr_pkg::csr_word_t mtvec_q;
	csr_pkg::csr_word_t mscratch_q;
	csr_pkg::csr_word_t mepc_q;
	csr_pkg::csr_word_t mcause_q;
	csr_pkg::csr_word_t mtval_q;

	csr_pkg::csr_word_t mstatus_rd;
	csr_pkg::csr_word_t mip_next;

	// irq lines into their mip slots
	always_comb begin
		mip_next = '0;
		mip_next[csr_pkg::IRQ_MSI] = irq_soft;
		mip_next[csr_pkg::IRQ_MTI] = irq_timer;
		mip_next[csr_pkg::IRQ_MEI] = irq_ext;
	end

	// mstatus as software sees it
	always_comb begin
		mstatus_rd = '0;
		mstatus_rd[csr_pkg::MSTATUS_MIE] = mstatus_mie_q;
		mstatus_rd[csr_pkg::MSTATUS_MPIE] = mstatus_mpie_q;
		// m mode only, so mpp is always 3
		mstatus_rd[csr_pkg::MSTATUS_MPP +: 2] = 2'b11;
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mstatus_mie_q <= 1'b0;
			mstatus_mpie_q <= 1'b0;
			mie_q <= '0;
			mip_q <= '0;
			mtvec_q <= '0;
			mscratch_q <= '0;
			mepc_q <= '0;
			mcause_q <= '0;
			mtval_q <= '0;
		end else begin
			// pending bits follow the lines, never software
			mip_q <= mip_next;
			if (trap_take) begin
				// stack the interrupt enable
				mstatus_mpie_q <= mstatus_mie_q;
				mstatus_mie_q <= 1'b0;
				mepc_q <= {trap_mepc[63:2], 2'b00};
				mcause_q <= trap_mcause;
				mtval_q <= trap_mtval;
			end else if (mret_take) begin
				// unstack
				mstatus_mie_q <= mstatus_mpie_q;
				mstatus_mpie_q <= 1'b1;
			end
			// csr_we is already low on a trap
			if (csr_we) begin
				case (csr_addr)
					csr_pkg::ADDR_MSTATUS: begin
						mstatus_mie_q <= csr_new[csr_pkg::MSTATUS_MIE];
						mstatus_mpie_q <= csr_new[csr_pkg::MSTATUS_MPIE];
					end
					csr_pkg::ADDR_MIE:      mie_q <= csr_new & csr_pkg::MIE_MASK;
					// direct mode only
					csr_pkg::ADDR_MTVEC:    mtvec_q <= {csr_new[63:2], 2'b00};
					csr_pkg::ADDR_MSCRATCH: mscratch_q <= csr_new;
					csr_pkg::ADDR_MEPC:     mepc_q <= {csr_new[63:2], 2'b00};
					csr_pkg::ADDR_MCAUSE:   mcause_q <= csr_new;
					csr_pkg::ADDR_MTVAL:    mtval_q <= csr_new;
					default: ;
				endcase
			end
		end
	end

	// read mux, old value in the same cycle
	always_comb begin
		case (csr_addr)
			csr_pkg::ADDR_MHARTID:  csr_rdata = csr_pkg::MHARTID_VALUE;
			csr_pkg::ADDR_MSTATUS:  csr_rdata = mstatus_rd;
			csr_pkg::ADDR_MISA:     csr_rdata = csr_pkg::MISA_VALUE;
			csr_pkg::ADDR_MIE:      csr_rdata = mie_q;
			csr_pkg::ADDR_MTVEC:    csr_rdata = mtvec_q;
			csr_pkg::ADDR_MSCRATCH: csr_rdata = mscratch_q;
			csr_pkg::ADDR_MEPC:     csr_rdata = mepc_q;
			csr_pkg::ADDR_MCAUSE:   csr_rdata = mcause_q;
			csr_pkg::ADDR_MTVAL:    csr_rdata = mtval_q;
			csr_pkg::ADDR_MIP:      csr_rdata = mip_q;
			csr_pkg::ADDR_MCYCLE:   csr_rdata = mcycle;
			csr_pkg::ADDR_MINSTRET: csr_rdata = minstret;
			// vendor, arch, impl ids and unknown addresses
			default:                csr_rdata = '0;
		endcase
	end

	assign mstatus_mie = mstatus_mie_q;
	assign mpending = mip_q & mie_q;
	assign mtvec_base = mtvec_q;
	assign mepc = mepc_q;

	// no vectored mode
	a_mtvec_direct: assert property (@(posedge CLK) disable iff (!rst_n)
		mtvec_q[1:0] == 2'b00);

	// handler always starts with interrupts masked
	a_trap_masks: assert property (@(posedge CLK) disable iff (!rst_n)
		trap_take |=> !mstatus_mie_q);

endmodule

`default_nettype wire

// ==== hdl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

	// one machine word on rv64
	typedef logic [63:0] csr_word_t;

	// csr address field of the instruction
	typedef logic [11:0] csr_addr_t;

	// low two bits of funct3
	// the immediate forms are folded in by the decoder
	typedef enum logic [1:0] {
		CSR_RW = 2'b01,
		CSR_RS = 2'b10,
		CSR_RC = 2'b11
	} csr_op_e;

	// machine information, all read only
	localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
	localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
	localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
	localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

	// machine trap setup
	localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
	localparam csr_addr_t ADDR_MISA      = 12'h301;
	localparam csr_addr_t ADDR_MIE       = 12'h304;
	localparam csr_addr_t ADDR_MTVEC     = 12'h305;

	// machine trap handling
	localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
	localparam csr_addr_t ADDR_MEPC      = 12'h341;
	localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
	localparam csr_addr_t ADDR_MTVAL     = 12'h343;
	localparam csr_addr_t ADDR_MIP       = 12'h344;

	// machine counters
	localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
	localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;

	// mstatus fields
	localparam int MSTATUS_MIE  = 3;
	localparam int MSTATUS_MPIE = 7;
	// low bit of the two bit mpp field
	localparam int MSTATUS_MPP  = 11;

	// interrupt numbers, same bit in mip, mie and the mcause code
	localparam int IRQ_MSI = 3;
	localparam int IRQ_MTI = 7;
	localparam int IRQ_MEI = 11;

	// mxl = 64 bit, extension I only
	localparam csr_word_t MISA_VALUE = 64'h8000_0000_0000_0100;

	// single hart
	localparam csr_word_t MHARTID_VALUE = 64'h0;

	// msi, mti, mei
	localparam csr_word_t MIE_MASK = 64'h0000_0000_0000_0888;

	// exception code for an illegal csr access
	localparam csr_word_t CAUSE_ILLEGAL_INSTR = 64'd2;

	// interrupt flag in mcause
	localparam csr_word_t CAUSE_INT_FLAG = 64'h8000_0000_0000_0000;

endpackage

`default_nettype wire

// ==== hdl/csr_unit.sv ====
`default_nettype none

module csr_unit (
	input wire logic                CLK,
	input wire logic                rst_n,
	// csr instruction
	input wire logic                csr_valid,
	input wire csr_pkg::csr_op_e    csr_op,
	input wire csr_pkg::csr_addr_t  csr_addr,
	input wire csr_pkg::csr_word_t  csr_wdata,
	input wire logic                csr_rs1_zero,
	output csr_pkg::csr_word_t      csr_rdata,
	// pipeline exceptions
	input wire logic                exc_valid,
	input wire csr_pkg::csr_word_t  exc_cause,
	input wire csr_pkg::csr_word_t  exc_tval,
	input wire csr_pkg::csr_word_t  cur_pc,
	// interrupt levels
	input wire logic                irq_soft,
	input wire logic                irq_timer,
	input wire logic                irq_ext,
	// retire and return
	input wire logic                instr_retire,
	input wire logic                mret,
	// redirects
	output logic                    trap_valid,
	output csr_pkg::csr_word_t      trap_pc,
	output logic                    mret_valid,
	output csr_pkg::csr_word_t      mret_pc
);

	wire logic               csr_illegal;
	wire logic               csr_we;
	wire csr_pkg::csr_word_t csr_new;
	wire logic               trap_take;
	wire csr_pkg::csr_word_t trap_mcause;
	wire csr_pkg::csr_word_t trap_mepc;
	wire csr_pkg::csr_word_t trap_mtval;
	wire logic               mret_take;
	wire logic               mstatus_mie;
	wire csr_pkg::csr_word_t mpending;
	wire csr_pkg::csr_word_t mtvec_base;
	wire csr_pkg::csr_word_t mepc;
	wire csr_pkg::csr_word_t mcycle;
	wire csr_pkg::csr_word_t minstret;

	// decode and new value, old value comes back from the read mux
	csr_exec u_exec (
		.csr_valid   (csr_valid),
		.csr_op      (csr_op),
		.csr_addr    (csr_addr),
		.csr_wdata   (csr_wdata),
		.csr_rs1_zero(csr_rs1_zero),
		.csr_old     (csr_rdata),
		.trap_take   (trap_take),
		.csr_illegal (csr_illegal),
		.csr_we      (csr_we),
		.csr_new     (csr_new)
	);

	csr_file u_file (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.csr_addr   (csr_addr),
		.csr_we     (csr_we),
		.csr_new    (csr_new),
		.irq_soft   (irq_soft),
		.irq_timer  (irq_timer),
		.irq_ext    (irq_ext),
		.trap_take  (trap_take),
		.trap_mcause(trap_mcause),
		.trap_mepc  (trap_mepc),
		.trap_mtval (trap_mtval),
		.mret_take  (mret_take),
		.mcycle     (mcycle),
		.minstret   (minstret),
		.csr_rdata  (csr_rdata),
		.mstatus_mie(mstatus_mie),
		.mpending   (mpending),
		.mtvec_base (mtvec_base),
		.mepc       (mepc)
	);

	csr_counters u_counters (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.instr_retire(instr_retire),
		.csr_addr    (csr_addr),
		.csr_we      (csr_we),
		.csr_new     (csr_new),
		.mcycle      (mcycle),
		.minstret    (minstret)
	);

	// trap priority and the two redirects
	trap_ctrl u_trap (
		.exc_valid  (exc_valid),
		.exc_cause  (exc_cause),
		.exc_tval   (exc_tval),
		.cur_pc     (cur_pc),
		.csr_illegal(csr_illegal),
		.mstatus_mie(mstatus_mie),
		.mpending   (mpending),
		.mtvec_base (mtvec_base),
		.mepc       (mepc),
		.mret       (mret),
		.trap_take  (trap_take),
		.trap_mcause(trap_mcause),
		.trap_mepc  (trap_mepc),
		.trap_mtval (trap_mtval),
		.mret_take  (mret_take),
		.trap_valid (trap_valid),
		.trap_pc    (trap_pc),
		.mret_valid (mret_valid),
		.mret_pc    (mret_pc)
	);

endmodule

`default_nettype wire

// ==== hdl/trap_ctrl.sv ====
`default_nettype none

module trap_ctrl (
	input wire logic                exc_valid,
	input wire csr_pkg::csr_word_t  exc_cause,
	input wire csr_pkg::csr_word_t  exc_tval,
	input wire csr_pkg::csr_word_t  cur_pc,
	input wire logic                csr_illegal,
	input wire logic                mstatus_mie,
	input wire csr_pkg::csr_word_t  mpending,
	input wire csr_pkg::csr_word_t  mtvec_base,
	input wire csr_pkg::csr_word_t  mepc,
	input wire logic                mret,
	output logic                    trap_take,
	output csr_pkg::csr_word_t      trap_mcause,
	output csr_pkg::csr_word_t      trap_mepc,
	output csr_pkg::csr_word_t      trap_mtval,
	output logic                    mret_take,
	output logic                    trap_valid,
	output csr_pkg::csr_word_t      trap_pc,
	output logic                    mret_valid,
	output csr_pkg::csr_word_t      mret_pc
);

	logic irq_ready;

	// interrupt cause, flag plus irq number
	function automatic csr_pkg::csr_word_t irq_cause(input int unsigned num);
		irq_cause = csr_pkg::CAUSE_INT_FLAG | csr_pkg::csr_word_t'(num);
	endfunction

	// global enable with something pending and enabled
	assign irq_ready = mstatus_mie && (mpending != '0);

	// exc, illegal csr, mei, msi, mti
	always_comb begin
		trap_take = 1'b1;
		trap_mcause = '0;
		// tval only carries data for pipeline exceptions
		trap_mtval = '0;
		if (exc_valid) begin
			trap_mcause = exc_cause;
			trap_mtval = exc_tval;
		end else if (csr_illegal) begin
			trap_mcause = csr_pkg::CAUSE_ILLEGAL_INSTR;
		end else if (irq_ready && mpending[csr_pkg::IRQ_MEI]) begin
			trap_mcause = irq_cause(csr_pkg::IRQ_MEI);
		end else if (irq_ready && mpending[csr_pkg::IRQ_MSI]) begin
			trap_mcause = irq_cause(csr_pkg::IRQ_MSI);
		end else if (irq_ready && mpending[csr_pkg::IRQ_MTI]) begin
			trap_mcause = irq_cause(csr_pkg::IRQ_MTI);
		end else begin
			trap_take = 1'b0;
		end
	end

	// faulting or interrupted instruction
	assign trap_mepc = cur_pc;

	// a trap in the same cycle wins over mret
	assign mret_take = mret && !trap_take;

	// redirects to the fetch stage
	assign trap_valid = trap_take;
	assign trap_pc = mtvec_base;
	assign mret_valid = mret_take;
	assign mret_pc = mepc;

	// pipeline never sends mret with a faulting instruction
	always_comb begin
		if (exc_valid) begin
			a_no_mret_with_exc: assert final (!mret)
				else $error("mret high in the same cycle as exc_valid");
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the csr unit testbench with verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_csr_unit \
	-f vlog.f \
	--Mdir obj_dir -o tb_csr_unit &&
./obj_dir/tb_csr_unit ||
{ echo "simulation failed" >&2; exit 1; }

// ==== verification/tb_csr_unit.sv ====
`default_nettype none

module tb_csr_unit;

	timeunit 1ns;
	timeprecision 1ps;

	logic CLK = 1'b0;
	logic rst_n;
	logic csr_valid;
	csr_pkg::csr_op_e csr_op;
	csr_pkg::csr_addr_t csr_addr;
	csr_pkg::csr_word_t csr_wdata;
	logic csr_rs1_zero;
	csr_pkg::csr_word_t csr_rdata;
	logic exc_valid;
	csr_pkg::csr_word_t exc_cause;
	csr_pkg::csr_word_t exc_tval;
	csr_pkg::csr_word_t cur_pc;
	logic irq_soft;
	logic irq_timer;
	logic irq_ext;
	logic instr_retire;
	logic mret;
	logic trap_valid;
	csr_pkg::csr_word_t trap_pc;
	logic mret_valid;
	csr_pkg::csr_word_t mret_pc;

	string test_name;

	// mirror of the machine state
	logic mdl_status_mie;
	logic mdl_status_mpie;
	csr_pkg::csr_word_t mdl_mie;
	csr_pkg::csr_word_t mdl_mip;
	csr_pkg::csr_word_t mdl_mtvec;
	csr_pkg::csr_word_t mdl_mscratch;
	csr_pkg::csr_word_t mdl_mepc;
	csr_pkg::csr_word_t mdl_mcause;
	csr_pkg::csr_word_t mdl_mtval;
	csr_pkg::csr_word_t mdl_mcycle;
	csr_pkg::csr_word_t mdl_minstret;

	always #50 CLK = ~CLK;

	csr_unit i_dut (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.csr_valid   (csr_valid),
		.csr_op      (csr_op),
		.csr_addr    (csr_addr),
		.csr_wdata   (csr_wdata),
		.csr_rs1_zero(csr_rs1_zero),
		.csr_rdata   (csr_rdata),
		.exc_valid   (exc_valid),
		.exc_cause   (exc_cause),
		.exc_tval    (exc_tval),
		.cur_pc      (cur_pc),
		.irq_soft    (irq_soft),
		.irq_timer   (irq_timer),
		.irq_ext     (irq_ext),
		.instr_retire(instr_retire),
		.mret        (mret),
		.trap_valid  (trap_valid),
		.trap_pc     (trap_pc),
		.mret_valid  (mret_valid),
		.mret_pc     (mret_pc)
	);

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("STATUS: FAIL");
		$fatal(1, "csr unit testbench stopped");
	endtask

	task automatic check_word(input string what, input csr_pkg::csr_word_t exp_val,
			input csr_pkg::csr_word_t act_val);
		if (act_val !== exp_val) begin
			report_failure($sformatf("MISMATCH %s %s expected 0x%016h actual 0x%016h",
				test_name, what, exp_val, act_val));
		end
	endtask

	task automatic check_flag(input string what, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			report_failure($sformatf("MISMATCH %s %s expected %b actual %b",
				test_name, what, exp_val, act_val));
		end
	endtask

	task automatic check_pc(input string what, input csr_pkg::csr_word_t exp_val,
			input csr_pkg::csr_word_t act_val);
		if (act_val !== exp_val) begin
			report_failure($sformatf("MISMATCH %s %s expected pc 0x%016h actual pc 0x%016h",
				test_name, what, exp_val, act_val));
		end
	endtask

	// the fifteen implemented addresses, writable ones first
	function automatic csr_pkg::csr_addr_t impl_addr(input int idx);
		case (idx)
			0:       return csr_pkg::ADDR_MSTATUS;
			1:       return csr_pkg::ADDR_MISA;
			2:       return csr_pkg::ADDR_MIE;
			3:       return csr_pkg::ADDR_MTVEC;
			4:       return csr_pkg::ADDR_MSCRATCH;
			5:       return csr_pkg::ADDR_MEPC;
			6:       return csr_pkg::ADDR_MCAUSE;
			7:       return csr_pkg::ADDR_MTVAL;
			8:       return csr_pkg::ADDR_MIP;
			9:       return csr_pkg::ADDR_MCYCLE;
			10:      return csr_pkg::ADDR_MINSTRET;
			11:      return csr_pkg::ADDR_MVENDORID;
			12:      return csr_pkg::ADDR_MARCHID;
			13:      return csr_pkg::ADDR_MIMPID;
			default: return csr_pkg::ADDR_MHARTID;
		endcase
	endfunction

	function automatic logic addr_known(input csr_pkg::csr_addr_t addr);
		int i;
		for (i = 0; i < 15; i++) begin
			if (addr == impl_addr(i)) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// old read value, and the stored value if the access writes
	function automatic csr_pkg::csr_word_t csr_expect(input csr_pkg::csr_addr_t addr,
			input csr_pkg::csr_op_e op, input csr_pkg::csr_word_t wdata,
			output csr_pkg::csr_word_t next_val);
		csr_pkg::csr_word_t old_val;
		csr_pkg::csr_word_t raw;
		case (addr)
			csr_pkg::ADDR_MSTATUS: begin
				// mpp fixed at 3
				old_val = 64'h1800;
				old_val[3] = mdl_status_mie;
				old_val[7] = mdl_status_mpie;
			end
			csr_pkg::ADDR_MISA:     old_val = csr_pkg::MISA_VALUE;
			csr_pkg::ADDR_MIE:      old_val = mdl_mie;
			csr_pkg::ADDR_MTVEC:    old_val = mdl_mtvec;
			csr_pkg::ADDR_MSCRATCH: old_val = mdl_mscratch;
			csr_pkg::ADDR_MEPC:     old_val = mdl_mepc;
			csr_pkg::ADDR_MCAUSE:   old_val = mdl_mcause;
			csr_pkg::ADDR_MTVAL:    old_val = mdl_mtval;
			csr_pkg::ADDR_MIP:      old_val = mdl_mip;
			csr_pkg::ADDR_MCYCLE:   old_val = mdl_mcycle;
			csr_pkg::ADDR_MINSTRET: old_val = mdl_minstret;
			default:                old_val = '0;
		endcase
		case (op)
			csr_pkg::CSR_RS: raw = old_val | wdata;
			csr_pkg::CSR_RC: raw = old_val & ~wdata;
			default:         raw = wdata;
		endcase
		// warl masks
		case (addr)
			csr_pkg::ADDR_MSTATUS: next_val = raw & 64'h88;
			csr_pkg::ADDR_MIE:     next_val = raw & 64'h888;
			csr_pkg::ADDR_MTVEC:   next_val = raw & ~64'h3;
			csr_pkg::ADDR_MEPC:    next_val = raw & ~64'h3;
			default:               next_val = raw;
		endcase
		return old_val;
	endfunction

	task automatic apply_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_word_t val);
		case (addr)
			csr_pkg::ADDR_MSTATUS: begin
				mdl_status_mie = val[3];
				mdl_status_mpie = val[7];
			end
			csr_pkg::ADDR_MIE:      mdl_mie = val;
			csr_pkg::ADDR_MTVEC:    mdl_mtvec = val;
			csr_pkg::ADDR_MSCRATCH: mdl_mscratch = val;
			csr_pkg::ADDR_MEPC:     mdl_mepc = val;
			csr_pkg::ADDR_MCAUSE:   mdl_mcause = val;
			csr_pkg::ADDR_MTVAL:    mdl_mtval = val;
			csr_pkg::ADDR_MCYCLE:   mdl_mcycle = val;
			csr_pkg::ADDR_MINSTRET: mdl_minstret = val;
			// misa, mip and the ids ignore writes
			default: ;
		endcase
	endtask

	task automatic reset_model();
		mdl_status_mie = 1'b0;
		mdl_status_mpie = 1'b0;
		mdl_mie = '0;
		mdl_mip = '0;
		mdl_mtvec = '0;
		mdl_mscratch = '0;
		mdl_mepc = '0;
		mdl_mcause = '0;
		mdl_mtval = '0;
		mdl_mcycle = '0;
		mdl_minstret = '0;
	endtask

	task automatic compare_and_step();
		csr_pkg::csr_word_t old_val;
		csr_pkg::csr_word_t new_val;
		csr_pkg::csr_word_t pend;
		csr_pkg::csr_word_t cause;
		csr_pkg::csr_word_t tval;
		logic wants_write;
		logic illegal;
		logic take;
		logic ret;
		old_val = csr_expect(csr_addr, csr_op, csr_wdata, new_val);
		wants_write = (csr_op == csr_pkg::CSR_RW) || !csr_rs1_zero;
		illegal = csr_valid && (!addr_known(csr_addr) ||
			(csr_addr[11:10] == 2'b11 && wants_write));
		pend = mdl_mip & mdl_mie;
		take = 1'b1;
		cause = '0;
		tval = '0;
		// exc, illegal, mei, msi, mti
		if (exc_valid) begin
			cause = exc_cause;
			tval = exc_tval;
		end else if (illegal) begin
			cause = 64'd2;
		end else if (mdl_status_mie && pend[11]) begin
			cause = 64'h8000_0000_0000_000B;
		end else if (mdl_status_mie && pend[3]) begin
			cause = 64'h8000_0000_0000_0003;
		end else if (mdl_status_mie && pend[7]) begin
			cause = 64'h8000_0000_0000_0007;
		end else begin
			take = 1'b0;
		end
		ret = mret && !take;
		if (csr_valid) begin
			check_word("csr_rdata", old_val, csr_rdata);
		end
		check_flag("trap_valid", take, trap_valid);
		check_pc("trap_pc", mdl_mtvec, trap_pc);
		check_flag("mret_valid", ret, mret_valid);
		check_pc("mret_pc", mdl_mepc, mret_pc);
		// state after this edge
		mdl_mcycle = mdl_mcycle + 64'd1;
		if (instr_retire) begin
			mdl_minstret = mdl_minstret + 64'd1;
		end
		mdl_mip = '0;
		mdl_mip[3] = irq_soft;
		mdl_mip[7] = irq_timer;
		mdl_mip[11] = irq_ext;
		if (take) begin
			mdl_status_mpie = mdl_status_mie;
			mdl_status_mie = 1'b0;
			mdl_mepc = cur_pc;
			mdl_mcause = cause;
			mdl_mtval = tval;
		end else if (ret) begin
			mdl_status_mie = mdl_status_mpie;
			mdl_status_mpie = 1'b1;
		end
		// a csr write replaces a counter step
		if (csr_valid && !illegal && wants_write && !take) begin
			apply_write(csr_addr, new_val);
		end
	endtask

	// inputs are stable since the falling edge
	always @(posedge CLK) begin
		if (!rst_n) begin
			reset_model();
		end else begin
			compare_and_step();
		end
	end

	function automatic csr_pkg::csr_word_t random_word();
		return {$urandom, $urandom};
	endfunction

	function automatic csr_pkg::csr_word_t random_pc();
		return {$urandom, $urandom} & ~64'h3;
	endfunction

	function automatic csr_pkg::csr_op_e random_op();
		case ($urandom_range(2))
			0:       return csr_pkg::CSR_RW;
			1:       return csr_pkg::CSR_RS;
			default: return csr_pkg::CSR_RC;
		endcase
	endfunction

	task automatic idle(input int cycles);
		repeat (cycles) @(negedge CLK);
	endtask

	// one cycle csr instruction
	task automatic csr_access(input csr_pkg::csr_op_e op, input csr_pkg::csr_addr_t addr,
			input csr_pkg::csr_word_t wdata, input logic rs1_zero);
		csr_valid = 1'b1;
		csr_op = op;
		csr_addr = addr;
		csr_wdata = wdata;
		csr_rs1_zero = rs1_zero;
		cur_pc = random_pc();
		@(negedge CLK);
		csr_valid = 1'b0;
	endtask

	// csrrs with x0, plain read
	task automatic csr_read(input csr_pkg::csr_addr_t addr);
		csr_access(csr_pkg::CSR_RS, addr, '0, 1'b1);
	endtask

	task automatic raise_exception(input csr_pkg::csr_word_t cause,
			input csr_pkg::csr_word_t tval);
		exc_valid = 1'b1;
		exc_cause = cause;
		exc_tval = tval;
		cur_pc = random_pc();
		@(negedge CLK);
		exc_valid = 1'b0;
	endtask

	task automatic return_from_trap();
		mret = 1'b1;
		@(negedge CLK);
		mret = 1'b0;
	endtask

	task automatic drive_irqs(input int irq_set);
		irq_soft = irq_set[0];
		irq_timer = irq_set[1];
		irq_ext = irq_set[2];
	endtask

	task automatic wait_for_trap(input int limit);
		int count;
		logic seen;
		count = 0;
		seen = 1'b0;
		while (!seen) begin
			@(posedge CLK);
			seen = trap_valid;
			if (!seen) begin
				count++;
				if (count > limit) begin
					report_failure($sformatf("%s: no trap_valid within %0d cycles",
						test_name, limit));
				end
			end
		end
		@(negedge CLK);
	endtask

	task automatic hold_without_trap(input int cycles);
		repeat (cycles) begin
			@(posedge CLK);
			check_flag("trap_valid while mie clear", 1'b0, trap_valid);
		end
		@(negedge CLK);
	endtask

	task automatic read_all_csrs();
		int i;
		test_name = "reset_identity";
		for (i = 0; i < 15; i++) begin
			csr_read(impl_addr(i));
		end
	endtask

	task automatic random_csr_ops(input int rounds);
		int i;
		csr_pkg::csr_addr_t addr;
		test_name = "random_csr";
		for (i = 0; i < rounds; i++) begin
			addr = impl_addr($urandom_range(7));
			csr_access(random_op(), addr, random_word(), $urandom_range(3) == 0);
			csr_read(addr);
		end
	endtask

	task automatic illegal_accesses();
		test_name = "illegal_access";
		csr_access(csr_pkg::CSR_RW, csr_pkg::ADDR_MTVEC, random_word(), 1'b0);
		// unmapped address
		csr_access(csr_pkg::CSR_RW, 12'h7C0, random_word(), 1'b0);
		csr_read(csr_pkg::ADDR_MCAUSE);
		csr_read(csr_pkg::ADDR_MEPC);
		csr_read(csr_pkg::ADDR_MTVAL);
		// writes into the read only range
		csr_access(csr_pkg::CSR_RW, csr_pkg::ADDR_MHARTID, random_word(), 1'b0);
		csr_read(csr_pkg::ADDR_MHARTID);
		csr_access(csr_pkg::CSR_RS, csr_pkg::ADDR_MVENDORID, 64'h1, 1'b0);
		csr_read(csr_pkg::ADDR_MVENDORID);
		csr_access(csr_pkg::CSR_RC, csr_pkg::ADDR_MARCHID, random_word() | 64'h1, 1'b0);
		csr_read(csr_pkg::ADDR_MARCHID);
		csr_read(csr_pkg::ADDR_MCAUSE);
		csr_read(csr_pkg::ADDR_MEPC);
	endtask

	task automatic exception_and_mret(input int rounds);
		int i;
		test_name = "exc_mret";
		for (i = 0; i < rounds; i++) begin
			// alternate the enable that gets stacked
			if (i % 2 == 0) begin
				csr_access(csr_pkg::CSR_RS, csr_pkg::ADDR_MSTATUS, 64'h8, 1'b0);
			end else begin
				csr_access(csr_pkg::CSR_RC, csr_pkg::ADDR_MSTATUS, 64'h8, 1'b0);
			end
			raise_exception(csr_pkg::csr_word_t'($urandom_range(15)), random_word());
			csr_read(csr_pkg::ADDR_MCAUSE);
			csr_read(csr_pkg::ADDR_MTVAL);
			csr_read(csr_pkg::ADDR_MEPC);
			csr_read(csr_pkg::ADDR_MSTATUS);
			return_from_trap();
			csr_read(csr_pkg::ADDR_MSTATUS);
		end
	endtask

	task automatic interrupt_entry(input int rounds);
		int i;
		test_name = "interrupts";
		csr_access(csr_pkg::CSR_RW, csr_pkg::ADDR_MIE, '1, 1'b0);
		for (i = 0; i < rounds; i++) begin
			csr_access(csr_pkg::CSR_RS, csr_pkg::ADDR_MSTATUS, 64'h8, 1'b0);
			drive_irqs($urandom_range(7, 1));
			wait_for_trap(8);
			drive_irqs(0);
			csr_read(csr_pkg::ADDR_MCAUSE);
			csr_read(csr_pkg::ADDR_MSTATUS);
			csr_read(csr_pkg::ADDR_MIP);
		end
		// global enable off, lines up
		csr_access(csr_pkg::CSR_RC, csr_pkg::ADDR_MSTATUS, 64'h8, 1'b0);
		drive_irqs(7);
		hold_without_trap(5);
		csr_read(csr_pkg::ADDR_MIP);
		drive_irqs(0);
		idle(2);
	endtask

	task automatic counter_updates();
		int i;
		test_name = "counters";
		csr_read(csr_pkg::ADDR_MCYCLE);
		idle(5);
		csr_read(csr_pkg::ADDR_MCYCLE);
		csr_read(csr_pkg::ADDR_MINSTRET);
		for (i = 0; i < 12; i++) begin
			instr_retire = ($urandom_range(1) == 1);
			@(negedge CLK);
		end
		instr_retire = 1'b0;
		csr_read(csr_pkg::ADDR_MINSTRET);
		csr_access(csr_pkg::CSR_RW, csr_pkg::ADDR_MCYCLE, random_word(), 1'b0);
		csr_read(csr_pkg::ADDR_MCYCLE);
		idle(3);
		csr_read(csr_pkg::ADDR_MCYCLE);
		csr_access(csr_pkg::CSR_RW, csr_pkg::ADDR_MINSTRET, random_word(), 1'b0);
		instr_retire = 1'b1;
		idle(2);
		instr_retire = 1'b0;
		csr_read(csr_pkg::ADDR_MINSTRET);
		// retire pulse and write in one cycle
		instr_retire = 1'b1;
		csr_access(csr_pkg::CSR_RW, csr_pkg::ADDR_MINSTRET, random_word(), 1'b0);
		instr_retire = 1'b0;
		csr_read(csr_pkg::ADDR_MINSTRET);
	endtask

	initial begin
		void'($urandom(47));
		test_name = "reset";
		rst_n = 1'b0;
		csr_valid = 1'b0;
		csr_op = csr_pkg::CSR_RW;
		csr_addr = '0;
		csr_wdata = '0;
		csr_rs1_zero = 1'b1;
		exc_valid = 1'b0;
		exc_cause = '0;
		exc_tval = '0;
		cur_pc = '0;
		irq_soft = 1'b0;
		irq_timer = 1'b0;
		irq_ext = 1'b0;
		instr_retire = 1'b0;
		mret = 1'b0;
		repeat (4) @(negedge CLK);
		rst_n = 1'b1;
		read_all_csrs();
		random_csr_ops(200);
		illegal_accesses();
		exception_and_mret(6);
		interrupt_entry(10);
		counter_updates();
		idle(2);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/csr_pkg.sv
hdl/csr_exec.sv
hdl/csr_file.sv
hdl/csr_counters.sv
hdl/trap_ctrl.sv
hdl/csr_unit.sv
verification/tb_csr_unit.sv
